// ==== verification/uart_stimulus.txt ====
# K <byte hex> <key mask hex with up at bit 4 then down left right enter>
# P <win> <row> <col> <report hex>
# report 00 drives the change and waits one bit without a frame of its own
# H <heartbeat report hex>
K 77 10
K 73 08
K 61 04
K 64 02
K 0d 01
K 78 00
P 0 0 1 41
P 0 1 0 44
P 0 1 1 45
P 0 2 1 00
P 0 3 2 00
P 0 3 3 49
P 0 3 3 4f
H 4f
P 1 3 3 57
H 57

// ==== tb.f ====
hdl/uart_pkg.sv
hdl/uart_rx.sv
hdl/uart_tx.sv
hdl/key_decoder.sv
hdl/status_reporter.sv
hdl/uart_controller.sv
verification/tb_uart_controller.sv

// ==== Bender.yml ====
package:
  name: uart_controller

sources:
  - files:
      - hdl/uart_pkg.sv
      - hdl/uart_rx.sv
      - hdl/uart_tx.sv
      - hdl/key_decoder.sv
      - hdl/status_reporter.sv
      - hdl/uart_controller.sv
  - target: simulation
    files:
      - verification/tb_uart_controller.sv

// ==== verification/tb_uart_controller.sv ====
`timescale 1ns/100ps

module tb_uart_controller;

    import uart_pkg::*;

    localparam int frame_cycles = 10 * clks_per_bit;

    logic clk;
    logic reset;
    logic rx_in;
    logic tx_out;
    key_pulses_t keys;
    board_pos_t position;

    int cycle = 0;
    int frames_started = 0;
    int last_start = 0;
    int pulse_cnt = 0;
    logic [4:0] key_seen = '0;
    bit moved = 1'b0;
    logic [7:0] frame_q[$];
    int start_q[$];

    uart_controller uart_controller_i (
        .clk      (clk),
        .reset    (reset),
        .rx_in    (rx_in),
        .tx_out   (tx_out),
        .keys     (keys),
        .position (position)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("error at %0t ns: %s, got %0h, expected %0h",
                                        $time, what, actual, expected));
        end
    endtask

    task automatic step_cycle();
        @(posedge clk);
        #10; // inputs change just after the edge.
    endtask

    task automatic send_serial_byte(input logic [7:0] data);
        rx_in = 1'b0;
        repeat (clks_per_bit) step_cycle();
        for (int i = 0; i < 8; i++) begin
            rx_in = data[i]; // lsb first.
            repeat (clks_per_bit) step_cycle();
        end
        rx_in = 1'b1;
        repeat (clks_per_bit) step_cycle();
    endtask

    task automatic pop_frame(input int limit, input string what, output logic [7:0] data,
                             output int start);
        int waited = 0;
        while (frame_q.size() == 0) begin
            if (waited == limit) stop_with_failure({"timeout waiting for ", what});
            step_cycle();
            waited++;
        end
        data = frame_q.pop_front();
        start = start_q.pop_front();
    endtask

    // rebuilds tx bytes from samples at bit centres.
    initial begin : tx_monitor
        int idle;
        int start;
        logic [7:0] data;
        forever begin
            idle = 0;
            while (tx_out !== 1'b0) begin
                if (idle == 2 * status_interval) begin
                    stop_with_failure("timeout waiting for any frame on tx_out");
                end
                @(negedge clk);
                idle++;
            end
            start = cycle;
            frames_started++;
            repeat (clks_per_bit / 2) @(negedge clk);
            check_value(tx_out, 1'b0, "tx start bit");
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge clk);
                data[i] = tx_out;
            end
            repeat (clks_per_bit) @(negedge clk);
            check_value(tx_out, 1'b1, "tx stop bit");
            frame_q.push_back(data);
            start_q.push_back(start);
        end
    end

    always @(negedge clk) begin
        if (keys != '0) begin
            key_seen = key_seen | keys;
            pulse_cnt++;
        end
    end

    initial begin : main
        int fd;
        int waited;
        int start;
        string line;
        logic [7:0] v0, v1, v2, v3;
        logic [7:0] data;
        rx_in = 1'b1;
        position = '0;
        reset = 1'b1;
        repeat (2) step_cycle();
        reset = 1'b0;
        step_cycle();
        check_value(tx_out, 1'b1, "tx_out after reset");
        check_value(keys, 0, "keys after reset");
        fd = $fopen("verification/uart_stimulus.txt", "r");
        if (fd == 0) stop_with_failure("could not open the stimulus file");
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#") continue;
            case (line[0])
                "K": begin
                    void'($sscanf(line, "K %h %h", v0, v1));
                    key_seen = '0;
                    pulse_cnt = 0;
                    send_serial_byte(v0);
                    waited = 0;
                    // the pulse often lands during the stop bit already.
                    while (pulse_cnt == 0 && waited < 2 * clks_per_bit) begin
                        step_cycle();
                        waited++;
                    end
                    if (v1 != 0 && pulse_cnt == 0) begin
                        stop_with_failure("timeout waiting for a key pulse");
                    end
                    repeat (2) step_cycle();
                    check_value(key_seen, v1, "key pulse mask");
                    check_value(pulse_cnt, v1 != 0, "key pulse count");
                end
                "P": begin
                    void'($sscanf(line, "P %d %d %d %h", v0, v1, v2, v3));
                    if (!moved) begin
                        check_value(frames_started, 0, "frames before the first move");
                    end
                    moved = 1'b1;
                    position = '{win: v0[0], row: v1[1:0], col: v2[1:0]};
                    if (v3 == 8'h00) begin
                        repeat (clks_per_bit) step_cycle(); // lands inside the running frame.
                    end else begin
                        pop_frame(2 * frame_cycles, "a position report", data, start);
                        check_value(data, v3, "position report byte");
                        last_start = start;
                    end
                end
                "H": begin
                    void'($sscanf(line, "H %h", v0));
                    pop_frame(status_interval + 2 * frame_cycles, "a heartbeat", data, start);
                    check_value(data, v0, "heartbeat byte");
                    check_value(start - last_start >= status_interval, 1, "heartbeat too early");
                    last_start = start;
                end
                default: stop_with_failure({"unknown stimulus command: ", line});
            endcase
        end
        $fclose(fd);
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== hdl/uart_controller.sv ====
`timescale 1ns/100ps

module uart_controller (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 rx_in,
    output logic                 tx_out,
    output uart_pkg::key_pulses_t keys,
    input  uart_pkg::board_pos_t  position
);

    logic [7:0] rx_data;
    logic       rx_valid;
    logic [7:0] tx_data;
    logic       tx_send;
    logic       tx_busy;

    uart_rx uart_rx_i (
        .clk      (clk),
        .reset    (reset),
        .rx_in    (rx_in),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    key_decoder key_decoder_i (
        .clk      (clk),
        .reset    (reset),
        .rx_data  (rx_data),
        .rx_valid (rx_valid),
        .keys     (keys)
    );

    status_reporter status_reporter_i (
        .clk      (clk),
        .reset    (reset),
        .position (position),
        .tx_busy  (tx_busy),
        .tx_data  (tx_data),
        .tx_send  (tx_send)
    );

    uart_tx uart_tx_i (
        .clk      (clk),
        .reset    (reset),
        .tx_data  (tx_data),
        .tx_send  (tx_send),
        .tx_out   (tx_out),
        .tx_busy  (tx_busy)
    );

endmodule

// ==== hdl/status_reporter.sv ====
`timescale 1ns/100ps

module status_reporter (
    input  logic                clk,
    input  logic                reset,
    input  uart_pkg::board_pos_t position,
    input  logic                tx_busy,
    output logic [7:0]          tx_data,
    output logic                tx_send
);

    import uart_pkg::*;

    board_pos_t prev_pos;
    logic [status_cnt_w-1:0] idle_cnt;
    logic tx_free;
    logic pos_changed;
    logic heartbeat_due;

    function automatic logic [7:0] report_byte(input board_pos_t pos);
        if (pos.win) begin
            return report_win;
        end
        return report_pos_base + {4'b0000, pos.row, pos.col};
    endfunction

    // busy only rises after the send cycle, so block that cycle too.
    assign tx_free = !tx_busy && !tx_send;
    assign pos_changed = (position != prev_pos);
    assign heartbeat_due = (idle_cnt == status_interval);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            prev_pos <= '0;
            idle_cnt <= '0;
            tx_send <= 1'b0;
        end else begin
            tx_send <= 1'b0;
            if (pos_changed && tx_free) begin
                tx_send <= 1'b1;
                prev_pos <= position;
                idle_cnt <= '0;
            end else if (heartbeat_due && tx_free) begin
                tx_send <= 1'b1;
                idle_cnt <= '0;
            end else if (!heartbeat_due) begin
                idle_cnt <= idle_cnt + 1'b1; // holds at the interval while busy.
            end
        end
    end

    // pending changes keep prev_pos stale until the line frees up.
    always_ff @(posedge clk) begin
        if ((pos_changed || heartbeat_due) && tx_free) begin
            tx_data <= report_byte(position);
        end
    end

endmodule

// ==== hdl/key_decoder.sv ====
`timescale 1ns/100ps

module key_decoder (
    input  logic                 clk,
    input  logic                 reset,
    input  logic [7:0]           rx_data,
    input  logic                 rx_valid,
    output uart_pkg::key_pulses_t keys
);

    import uart_pkg::*;

    key_code_e code;

    assign code = key_code_e'(rx_data);

    // the default clear ends every pulse after one cycle.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            keys <= '0;
        end else begin
            keys <= '0;
            if (rx_valid) begin
                case (code)
                    key_up:    keys.up <= 1'b1;
                    key_down:  keys.down <= 1'b1;
                    key_left:  keys.left <= 1'b1;
                    key_right: keys.right <= 1'b1;
                    key_enter: keys.enter <= 1'b1;
                    default:   ; // unknown bytes are ignored.
                endcase
            end
        end
    end

endmodule

// ==== hdl/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] tx_data,
    input  logic       tx_send,
    output logic       tx_out,
    output logic       tx_busy
);

    import uart_pkg::*;

    tx_state_e state;
    logic [bit_cnt_w-1:0] clk_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift_reg;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= tx_st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            case (state)
                tx_st_idle: begin
                    clk_cnt <= '0;
                    bit_idx <= '0;
                    if (tx_send) state <= tx_st_start;
                end
                tx_st_start: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == clks_per_bit - 1) begin
                        clk_cnt <= '0;
                        state <= tx_st_data;
                    end
                end
                tx_st_data: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == clks_per_bit - 1) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= tx_st_stop;
                    end
                end
                tx_st_stop: begin
                    clk_cnt <= clk_cnt + 1'b1;
                    if (clk_cnt == clks_per_bit - 1) state <= tx_st_idle;
                end
                default: state <= tx_st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == tx_st_idle && tx_send) begin
            shift_reg <= tx_data;
        end else if (state == tx_st_data && clk_cnt == clks_per_bit - 1) begin
            shift_reg <= {1'b0, shift_reg[7:1]}; // next bit into position 0.
        end
    end

    always_comb begin
        case (state)
            tx_st_start: tx_out = 1'b0;
            tx_st_data:  tx_out = shift_reg[0];
            default:     tx_out = 1'b1;
        endcase
    end

    assign tx_busy = (state != tx_st_idle);

endmodule

// ==== hdl/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
    input  logic       clk,
    input  logic       reset,
    input  logic       rx_in,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    import uart_pkg::*;

    logic rx_meta;
    logic rx_sync;
    rx_state_e state;
    logic [bit_cnt_w-1:0] clk_cnt;
    logic [2:0] bit_idx;
    logic [7:0] shift_reg;

    // line idles high, so the synchroniser resets to one.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx_in;
            rx_sync <= rx_meta;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= rx_st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            case (state)
                rx_st_idle: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= rx_st_start;
                end
                rx_st_start: begin
                    if (clk_cnt == clks_per_bit / 2 - 1) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state <= rx_sync ? rx_st_idle : rx_st_data; // glitch rejected.
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_st_data: begin
                    if (clk_cnt == clks_per_bit - 1) begin
                        clk_cnt <= '0;
                        if (bit_idx == 3'd7) state <= rx_st_stop;
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                rx_st_stop: begin
                    if (clk_cnt == clks_per_bit - 1) begin
                        rx_valid <= rx_sync; // framing error drops the byte.
                        state <= rx_st_idle;
                    end else begin
                        clk_cnt <= clk_cnt + 1'b1;
                    end
                end
                default: state <= rx_st_idle;
            endcase
        end
    end

    // lsb first, sampled at bit centre.
    always_ff @(posedge clk) begin
        if (state == rx_st_data && clk_cnt == clks_per_bit - 1) begin
            shift_reg <= {rx_sync, shift_reg[7:1]};
        end
    end

    assign rx_data = shift_reg;

endmodule

// ==== hdl/uart_pkg.sv ====
package uart_pkg;

    // serial timing, small values for simulation. a board build raises these.
    localparam int clks_per_bit = 16;
    localparam int status_interval = 2000;

    localparam int bit_cnt_w = $clog2(clks_per_bit);
    localparam int status_cnt_w = $clog2(status_interval + 1);

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } rx_state_e;

    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_e;

    // ascii bytes the host terminal sends.
    typedef enum logic [7:0] {
        key_up    = 8'h77, // 'w'.
        key_down  = 8'h73, // 's'.
        key_left  = 8'h61, // 'a'.
        key_right = 8'h64, // 'd'.
        key_enter = 8'h0d
    } key_code_e;

    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic enter;
    } key_pulses_t;

    typedef struct packed {
        logic       win;
        logic [1:0] row;
        logic [1:0] col;
    } board_pos_t;

    localparam logic [7:0] report_win = 8'h57;
    localparam logic [7:0] report_pos_base = 8'h40; // '@' is row 0, col 0.

endpackage
